// ==== design/tcp_consts.svh ====
`ifndef TCP_CONSTS_SVH
`define TCP_CONSTS_SVH

// stream blocks behind the demux and arbiter
`define TCP_NUM_STREAMS 4

// payload bytes kept per stream, longer payloads are cut
`define TCP_BUF_DEPTH 16

// cpu word addresses
`define TCP_REG_PORT_BASE 0
`define TCP_REG_CTRL 4
`define TCP_REG_RX_COUNT_BASE 8
`define TCP_REG_DROP_COUNT 12

`endif

// ==== design/tcp_pkg.sv ====
package tcp_pkg;

    // one byte of a stream
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
        logic       last;
    } ip_beat_t;

    // header ports, source first as on the wire
    typedef struct packed {
        logic [15:0] src;
        logic [15:0] dst;
    } tcp_ports_t;

    typedef struct packed {
        logic        req;
        logic        is_wr;
        logic [5:0]  addr;
        logic [31:0] wr_data;
    } cpu_req_t;

    typedef struct packed {
        logic        rd_ack;
        logic        wr_ack;
        logic [31:0] rd_data;
    } cpu_rsp_t;

    typedef enum logic {
        DECAP_HEADER,
        DECAP_PAYLOAD
    } decap_state_e;

    typedef enum logic [2:0] {
        STREAM_IDLE,
        STREAM_RECEIVE,
        STREAM_REQUEST,
        STREAM_SEND_HEADER,
        STREAM_SEND_PAYLOAD
    } stream_state_e;

endpackage

// ==== design/tcp_regfile.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_regfile (
    input  logic                          i_clk,
    input  logic                          i_reset,

    input  tcp_pkg::cpu_req_t             i_cpu_req,
    output tcp_pkg::cpu_rsp_t             o_cpu_rsp,

    output logic [15:0]                   o_stream_ports [`TCP_NUM_STREAMS],
    output logic [`TCP_NUM_STREAMS-1:0]   o_stream_enable,
    input  logic [`TCP_NUM_STREAMS-1:0]   i_rx_accept,
    input  logic                          i_rx_drop
);

    localparam int N = `TCP_NUM_STREAMS;

    logic [15:0] port_q [N];
    logic [N-1:0] enable_q;
    logic [31:0] rx_count_q [N];
    logic [31:0] drop_count_q;
    logic [31:0] rd_data;
    logic wr_en;
    logic rd_en;

    assign wr_en = i_cpu_req.req && i_cpu_req.is_wr;
    assign rd_en = i_cpu_req.req && !i_cpu_req.is_wr;

    // read mux, unmapped words read as zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < N; i++) begin
            if (i_cpu_req.addr == 6'(`TCP_REG_PORT_BASE + i)) begin
                rd_data = {16'h0000, port_q[i]};
            end
            if (i_cpu_req.addr == 6'(`TCP_REG_RX_COUNT_BASE + i)) begin
                rd_data = rx_count_q[i];
            end
        end
        if (i_cpu_req.addr == 6'(`TCP_REG_CTRL)) begin
            rd_data = 32'(enable_q);
        end
        if (i_cpu_req.addr == 6'(`TCP_REG_DROP_COUNT)) begin
            rd_data = drop_count_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int i = 0; i < N; i++) begin
                port_q[i] <= '0;
                rx_count_q[i] <= '0;
            end
            enable_q <= '0;
            drop_count_q <= '0;
            o_cpu_rsp <= '0;
        end else begin
            // ack one cycle after the strobe
            o_cpu_rsp.rd_ack <= rd_en;
            o_cpu_rsp.wr_ack <= wr_en;
            o_cpu_rsp.rd_data <= rd_en ? rd_data : 32'h0;

            for (int i = 0; i < N; i++) begin
                if (wr_en && i_cpu_req.addr == 6'(`TCP_REG_PORT_BASE + i)) begin
                    port_q[i] <= i_cpu_req.wr_data[15:0];
                end
                if (i_rx_accept[i]) begin
                    rx_count_q[i] <= rx_count_q[i] + 32'd1;
                end
            end
            if (wr_en && i_cpu_req.addr == 6'(`TCP_REG_CTRL)) begin
                enable_q <= i_cpu_req.wr_data[N-1:0];
            end
            // counter writes fall through with only the ack
            if (i_rx_drop) begin
                drop_count_q <= drop_count_q + 32'd1;
            end
        end
    end

    assign o_stream_ports = port_q;
    assign o_stream_enable = enable_q;

endmodule

// ==== design/tcp_dest_decap.sv ====
`timescale 1ns/1ps

module tcp_dest_decap (
    input  logic                  i_clk,
    input  logic                  i_reset,

    input  tcp_pkg::ip_beat_t     i_rx,
    output tcp_pkg::ip_beat_t     o_payload,

    output tcp_pkg::tcp_ports_t   o_ports,
    output logic                  o_ports_valid
);

    tcp_pkg::decap_state_e state_q;
    logic [1:0] hdr_cnt_q;
    logic [31:0] hdr_q;
    logic first_q;

    // src in the upper half, both msb first
    assign o_ports = tcp_pkg::tcp_ports_t'(hdr_q);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= tcp_pkg::DECAP_HEADER;
            hdr_cnt_q <= '0;
            hdr_q <= '0;
            first_q <= 1'b0;
            o_payload <= '0;
            o_ports_valid <= 1'b0;
        end else begin
            o_payload <= '0;
            o_ports_valid <= 1'b0;
            case (state_q)
                tcp_pkg::DECAP_HEADER: begin
                    if (i_rx.valid) begin
                        hdr_q <= {hdr_q[23:0], i_rx.data};
                        if (i_rx.last) begin
                            // short segment, nothing goes out
                            hdr_cnt_q <= '0;
                        end else if (hdr_cnt_q == 2'd3) begin
                            hdr_cnt_q <= '0;
                            first_q <= 1'b1;
                            state_q <= tcp_pkg::DECAP_PAYLOAD;
                        end else begin
                            hdr_cnt_q <= hdr_cnt_q + 2'd1;
                        end
                    end
                end
                tcp_pkg::DECAP_PAYLOAD: begin
                    if (i_rx.valid) begin
                        o_payload <= i_rx;
                        o_ports_valid <= first_q;
                        first_q <= 1'b0;
                        if (i_rx.last) begin
                            state_q <= tcp_pkg::DECAP_HEADER;
                        end
                    end
                end
                default: begin
                    state_q <= tcp_pkg::DECAP_HEADER;
                end
            endcase
        end
    end

endmodule

// ==== design/tcp_rx_demux.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_rx_demux (
    input  logic                          i_clk,
    input  logic                          i_reset,

    input  tcp_pkg::ip_beat_t             i_payload,
    input  tcp_pkg::tcp_ports_t           i_ports,
    input  logic                          i_ports_valid,

    input  logic [15:0]                   i_stream_ports [`TCP_NUM_STREAMS],
    input  logic [`TCP_NUM_STREAMS-1:0]   i_stream_enable,
    input  logic [`TCP_NUM_STREAMS-1:0]   i_stream_busy,

    output tcp_pkg::ip_beat_t             o_stream_rx [`TCP_NUM_STREAMS],
    output logic [15:0]                   o_remote_port,
    output logic                          o_drop
);

    localparam int N = `TCP_NUM_STREAMS;
    localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

    logic match_found;
    logic [SEL_W-1:0] match_sel;
    logic hit_q;
    logic [SEL_W-1:0] sel_q;
    logic cur_hit;
    logic [SEL_W-1:0] cur_sel;

    // walk downwards so the lowest index wins
    always_comb begin
        match_found = 1'b0;
        match_sel = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (i_stream_enable[i] && !i_stream_busy[i] &&
                i_stream_ports[i] == i_ports.dst) begin
                match_found = 1'b1;
                match_sel = SEL_W'(i);
            end
        end
    end

    // first beat steers directly, the rest use the latched choice
    assign cur_hit = i_ports_valid ? match_found : hit_q;
    assign cur_sel = i_ports_valid ? match_sel : sel_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            hit_q <= 1'b0;
            sel_q <= '0;
            o_remote_port <= '0;
            o_drop <= 1'b0;
            for (int i = 0; i < N; i++) begin
                o_stream_rx[i] <= '0;
            end
        end else begin
            o_drop <= i_ports_valid && !match_found;
            if (i_ports_valid) begin
                sel_q <= match_sel;
                o_remote_port <= i_ports.src;
            end
            if (i_payload.valid && i_payload.last) begin
                hit_q <= 1'b0;
            end else if (i_ports_valid) begin
                hit_q <= match_found;
            end
            for (int i = 0; i < N; i++) begin
                if (i_payload.valid && cur_hit && cur_sel == SEL_W'(i)) begin
                    o_stream_rx[i] <= i_payload;
                end else begin
                    o_stream_rx[i] <= '0;
                end
            end
        end
    end

endmodule

// ==== design/tcp_tx_arb_mux.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_tx_arb_mux (
    input  logic                          i_clk,
    input  logic                          i_reset,

    input  logic [`TCP_NUM_STREAMS-1:0]   i_req,
    input  tcp_pkg::ip_beat_t             i_tx [`TCP_NUM_STREAMS],

    output logic [`TCP_NUM_STREAMS-1:0]   o_grant,
    output tcp_pkg::ip_beat_t             o_tx
);

    localparam int N = `TCP_NUM_STREAMS;
    localparam int SEL_W = (N > 1) ? $clog2(N) : 1;

    logic [SEL_W-1:0] ptr_q;
    logic [SEL_W-1:0] pick;
    logic pick_found;
    tcp_pkg::ip_beat_t sel_beat;

    // next requester after the last granted one
    always_comb begin
        pick_found = 1'b0;
        pick = ptr_q;
        for (int k = N; k >= 1; k--) begin
            if (i_req[(int'(ptr_q) + k) % N]) begin
                pick_found = 1'b1;
                pick = SEL_W'((int'(ptr_q) + k) % N);
            end
        end
    end

    assign sel_beat = i_tx[ptr_q];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ptr_q <= '0;
            o_grant <= '0;
            o_tx <= '0;
        end else begin
            o_tx <= (|o_grant) ? sel_beat : '0;
            if (|o_grant) begin
                // hold for the whole segment
                if (sel_beat.valid && sel_beat.last) begin
                    o_grant <= '0;
                end
            end else if (pick_found) begin
                o_grant <= N'(1) << pick;
                ptr_q <= pick;
            end
        end
    end

endmodule

// ==== design/tcp_stream.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_stream (
    input  logic                i_clk,
    input  logic                i_reset,

    input  tcp_pkg::ip_beat_t   i_rx,
    input  logic [15:0]         i_remote_port,
    input  logic [15:0]         i_local_port,

    input  logic                i_grant,
    output logic                o_req,
    output tcp_pkg::ip_beat_t   o_tx,

    output logic                o_busy,
    output logic                o_accept
);

    localparam int DEPTH = `TCP_BUF_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int LEN_W = $clog2(DEPTH + 1);

    tcp_pkg::stream_state_e state_q;
    logic [7:0] mem [DEPTH];
    logic [LEN_W-1:0] len_q;
    logic [IDX_W-1:0] rd_idx_q;
    logic [1:0] hdr_idx_q;
    logic [15:0] remote_q;
    logic [7:0] hdr_byte;
    logic pay_last;
    logic wr_en;
    logic [IDX_W-1:0] wr_idx;

    // echo header: our port, then theirs
    always_comb begin
        case (hdr_idx_q)
            2'd0: hdr_byte = i_local_port[15:8];
            2'd1: hdr_byte = i_local_port[7:0];
            2'd2: hdr_byte = remote_q[15:8];
            default: hdr_byte = remote_q[7:0];
        endcase
    end

    assign pay_last = (LEN_W'(rd_idx_q) == len_q - LEN_W'(1));

    always_comb begin
        o_tx = '0;
        case (state_q)
            tcp_pkg::STREAM_SEND_HEADER: begin
                o_tx.valid = 1'b1;
                o_tx.data = hdr_byte;
            end
            tcp_pkg::STREAM_SEND_PAYLOAD: begin
                o_tx.valid = 1'b1;
                o_tx.data = mem[rd_idx_q];
                o_tx.last = pay_last;
            end
            default: begin
                o_tx = '0;
            end
        endcase
    end

    // request drops together with the last beat
    assign o_req = (state_q == tcp_pkg::STREAM_REQUEST) ||
                   (state_q == tcp_pkg::STREAM_SEND_HEADER) ||
                   (state_q == tcp_pkg::STREAM_SEND_PAYLOAD && !pay_last);
    assign o_busy = (state_q != tcp_pkg::STREAM_IDLE);

    // bytes past the buffer depth are discarded
    assign wr_en = i_rx.valid && ((state_q == tcp_pkg::STREAM_IDLE) ||
                   (state_q == tcp_pkg::STREAM_RECEIVE && len_q < LEN_W'(DEPTH)));
    assign wr_idx = (state_q == tcp_pkg::STREAM_IDLE) ? '0 : len_q[IDX_W-1:0];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem[wr_idx] <= i_rx.data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q <= tcp_pkg::STREAM_IDLE;
            len_q <= '0;
            rd_idx_q <= '0;
            hdr_idx_q <= '0;
            remote_q <= '0;
            o_accept <= 1'b0;
        end else begin
            o_accept <= 1'b0;
            case (state_q)
                tcp_pkg::STREAM_IDLE: begin
                    if (i_rx.valid) begin
                        remote_q <= i_remote_port;
                        len_q <= LEN_W'(1);
                        o_accept <= i_rx.last;
                        state_q <= i_rx.last ? tcp_pkg::STREAM_REQUEST
                                             : tcp_pkg::STREAM_RECEIVE;
                    end
                end
                tcp_pkg::STREAM_RECEIVE: begin
                    if (wr_en) begin
                        len_q <= len_q + LEN_W'(1);
                    end
                    if (i_rx.valid && i_rx.last) begin
                        o_accept <= 1'b1;
                        state_q <= tcp_pkg::STREAM_REQUEST;
                    end
                end
                tcp_pkg::STREAM_REQUEST: begin
                    if (i_grant) begin
                        hdr_idx_q <= '0;
                        state_q <= tcp_pkg::STREAM_SEND_HEADER;
                    end
                end
                tcp_pkg::STREAM_SEND_HEADER: begin
                    hdr_idx_q <= hdr_idx_q + 2'd1;
                    if (hdr_idx_q == 2'd3) begin
                        rd_idx_q <= '0;
                        state_q <= tcp_pkg::STREAM_SEND_PAYLOAD;
                    end
                end
                tcp_pkg::STREAM_SEND_PAYLOAD: begin
                    rd_idx_q <= rd_idx_q + IDX_W'(1);
                    if (pay_last) begin
                        state_q <= tcp_pkg::STREAM_IDLE;
                    end
                end
                default: begin
                    state_q <= tcp_pkg::STREAM_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== design/tcp_offload.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_offload (
    input  logic                i_clk,
    input  logic                i_reset,

    input  tcp_pkg::cpu_req_t   i_cpu_req,
    output tcp_pkg::cpu_rsp_t   o_cpu_rsp,

    input  tcp_pkg::ip_beat_t   i_rx,
    output tcp_pkg::ip_beat_t   o_tx
);

    localparam int N = `TCP_NUM_STREAMS;

    logic [15:0] stream_ports [N];
    logic [N-1:0] stream_enable;
    logic [N-1:0] stream_accept;
    logic [N-1:0] stream_busy;
    logic [N-1:0] stream_req;
    logic [N-1:0] stream_grant;
    logic rx_drop;

    tcp_pkg::ip_beat_t decap_payload;
    tcp_pkg::tcp_ports_t decap_ports;
    logic decap_ports_valid;

    tcp_pkg::ip_beat_t stream_rx [N];
    tcp_pkg::ip_beat_t stream_tx [N];
    logic [15:0] remote_port;

    tcp_regfile u_tcp_regfile (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_cpu_req        (i_cpu_req),
        .o_cpu_rsp        (o_cpu_rsp),
        .o_stream_ports   (stream_ports),
        .o_stream_enable  (stream_enable),
        .i_rx_accept      (stream_accept),
        .i_rx_drop        (rx_drop)
    );

    tcp_dest_decap u_tcp_dest_decap (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_rx             (i_rx),
        .o_payload        (decap_payload),
        .o_ports          (decap_ports),
        .o_ports_valid    (decap_ports_valid)
    );

    tcp_rx_demux u_tcp_rx_demux (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_payload        (decap_payload),
        .i_ports          (decap_ports),
        .i_ports_valid    (decap_ports_valid),
        .i_stream_ports   (stream_ports),
        .i_stream_enable  (stream_enable),
        .i_stream_busy    (stream_busy),
        .o_stream_rx      (stream_rx),
        .o_remote_port    (remote_port),
        .o_drop           (rx_drop)
    );

    // one echo buffer per connection
    generate
        for (genvar i = 0; i < N; i++) begin : g_streams
            tcp_stream u_tcp_stream (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_rx           (stream_rx[i]),
                .i_remote_port  (remote_port),
                .i_local_port   (stream_ports[i]),
                .i_grant        (stream_grant[i]),
                .o_req          (stream_req[i]),
                .o_tx           (stream_tx[i]),
                .o_busy         (stream_busy[i]),
                .o_accept       (stream_accept[i])
            );
        end
    endgenerate

    tcp_tx_arb_mux u_tcp_tx_arb_mux (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_req            (stream_req),
        .i_tx             (stream_tx),
        .o_grant          (stream_grant),
        .o_tx             (o_tx)
    );

endmodule

// ==== tb/tcp_offload_assert.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_offload_assert (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  tcp_pkg::cpu_req_t             i_cpu_req,
    input  tcp_pkg::cpu_rsp_t             i_cpu_rsp,
    input  tcp_pkg::ip_beat_t             i_tx,
    input  logic [`TCP_NUM_STREAMS-1:0]   i_grant
);

    int fail_count = 0;
    logic rd_req;
    logic wr_req;

    assign rd_req = i_cpu_req.req && !i_cpu_req.is_wr;
    assign wr_req = i_cpu_req.req && i_cpu_req.is_wr;

    grant_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        $onehot0(i_grant))
        else begin
            fail_count++;
            $error("arbiter grant is not one-hot");
        end

    acks_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_cpu_rsp.rd_ack && i_cpu_rsp.wr_ack))
        else begin
            fail_count++;
            $error("rd_ack and wr_ack high together");
        end

    // ack exactly one cycle behind its strobe
    rd_ack_timing: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cpu_rsp.rd_ack == $past(rd_req))
        else begin
            fail_count++;
            $error("rd_ack not one cycle after read");
        end

    wr_ack_timing: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cpu_rsp.wr_ack == $past(wr_req))
        else begin
            fail_count++;
            $error("wr_ack not one cycle after write");
        end

    tx_quiet_in_reset: assert property (@(posedge i_clk)
        i_reset |=> !i_tx.valid)
        else begin
            fail_count++;
            $error("o_tx valid during reset");
        end

endmodule

bind tcp_offload tcp_offload_assert u_assert (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_cpu_req  (i_cpu_req),
    .i_cpu_rsp  (o_cpu_rsp),
    .i_tx       (o_tx),
    .i_grant    (stream_grant)
);

// ==== tb/tcp_offload_tb.sv ====
`timescale 1ns/1ps
`include "tcp_consts.svh"

module tcp_offload_tb;

    localparam int N = `TCP_NUM_STREAMS;
    localparam int CLK_PERIOD = 100;
    localparam int ECHO_LEN = 20;
    localparam int DROP_LEN = 6;
    localparam int IDLE_CYCLES = 40;
    localparam int WAIT_LIMIT = 300;
    // per-test beat counts for the watchdog
    localparam int REG_BEATS = 2 * (2 * N + 5);
    localparam int ECHO_BEATS = 2 * (4 + ECHO_LEN) + IDLE_CYCLES;
    localparam int DROP_BEATS = 2 * (4 + DROP_LEN) + IDLE_CYCLES + 6;
    localparam int ARB_BEATS = 2 * (4 * N + 5 + 9 + 18 + 12) + IDLE_CYCLES;
    localparam int COUNT_BEATS = 2 * (N + 1);
    localparam int MARGIN = 8;
    localparam int WATCHDOG_CYCLES =
        (4 + REG_BEATS + ECHO_BEATS + DROP_BEATS + ARB_BEATS + COUNT_BEATS) * MARGIN;

    logic i_clk = 1'b0;
    logic i_reset;
    tcp_pkg::cpu_req_t i_cpu_req;
    tcp_pkg::cpu_rsp_t cpu_rsp;
    tcp_pkg::ip_beat_t i_rx;
    tcp_pkg::ip_beat_t tx;

    logic [31:0] lcg_state = 32'h5f87;
    logic [7:0] sent_pay [N][32];
    logic [15:0] sent_src [N];
    int sent_len [N];
    int exp_rx [N];
    int exp_drops;

    // o_tx capture
    tcp_pkg::ip_beat_t tx_beats [$];
    int seg_start [$];
    int seg_len [$];
    int cur_len = 0;

    tcp_offload dut0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_cpu_req  (i_cpu_req),
        .o_cpu_rsp  (cpu_rsp),
        .i_rx       (i_rx),
        .o_tx       (tx)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    always @(negedge i_clk) begin
        if (!i_reset && tx.valid) begin
            if (cur_len == 0) begin
                seg_start.push_back(tx_beats.size());
            end
            tx_beats.push_back(tx);
            cur_len++;
            if (tx.last) begin
                seg_len.push_back(cur_len);
                cur_len = 0;
            end
        end
    end

    always @(negedge i_clk) begin
        if (dut0.u_assert.fail_count != 0) begin
            report_failure("a bound assertion on the DUT failed");
        end
    end

    function automatic logic [7:0] next_rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic logic [15:0] stream_port(input int n);
        case (n)
            0: return 16'h0050;
            1: return 16'h01bb;
            2: return 16'h1f90;
            default: return 16'hc350;
        endcase
    endfunction

    function automatic int arb_len(input int n);
        case (n)
            0: return 5;
            1: return 9;
            2: return 18;
            default: return 12;
        endcase
    endfunction

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_failure(input string msg);
        $display("error at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic compare_rsp(input tcp_pkg::cpu_rsp_t got, input tcp_pkg::cpu_rsp_t exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_ports(input tcp_pkg::tcp_ports_t got,
                                 input tcp_pkg::tcp_ports_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic compare_beat(input tcp_pkg::ip_beat_t got, input tcp_pkg::ip_beat_t exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic cpu_write(input logic [5:0] addr, input logic [31:0] data);
        tcp_pkg::cpu_rsp_t exp;
        exp.rd_ack = 1'b0;
        exp.wr_ack = 1'b1;
        exp.rd_data = 32'h0;
        @(negedge i_clk);
        i_cpu_req.req = 1'b1;
        i_cpu_req.is_wr = 1'b1;
        i_cpu_req.addr = addr;
        i_cpu_req.wr_data = data;
        @(negedge i_clk);
        i_cpu_req = '0;
        compare_rsp(cpu_rsp, exp, "write acknowledge");
    endtask

    task automatic read_expect(input logic [5:0] addr, input logic [31:0] data,
                               input string what);
        tcp_pkg::cpu_rsp_t exp;
        exp.rd_ack = 1'b1;
        exp.wr_ack = 1'b0;
        exp.rd_data = data;
        @(negedge i_clk);
        i_cpu_req.req = 1'b1;
        i_cpu_req.is_wr = 1'b0;
        i_cpu_req.addr = addr;
        i_cpu_req.wr_data = 32'h0;
        @(negedge i_clk);
        i_cpu_req = '0;
        compare_rsp(cpu_rsp, exp, what);
    endtask

    // header then payload, one beat per falling edge
    task automatic send_segment(input int slot, input logic [15:0] src,
                                input logic [15:0] dst, input int len);
        logic [31:0] hdr;
        tcp_pkg::ip_beat_t beat;
        int j;
        hdr = {src, dst};
        sent_src[slot] = src;
        sent_len[slot] = len;
        for (j = 0; j < len; j++) begin
            sent_pay[slot][j] = next_rand_byte();
        end
        for (j = 0; j < 4 + len; j++) begin
            @(negedge i_clk);
            beat.valid = 1'b1;
            beat.data = (j < 4) ? hdr[31 - 8 * j -: 8] : sent_pay[slot][j - 4];
            beat.last = (j == 3 + len);
            i_rx = beat;
        end
    endtask

    task automatic rx_idle();
        @(negedge i_clk);
        i_rx = '0;
    endtask

    task automatic wait_segments(input int count);
        int waited;
        waited = 0;
        while (seg_len.size() < count) begin
            @(negedge i_clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("timed out waiting for an echo segment on o_tx");
            end
        end
    endtask

    // echo must carry our port, the sender's port, then the cut payload
    task automatic check_segment(input int k, input int slot, input logic [15:0] local_port);
        int start;
        int pay_len;
        int exp_len;
        int i;
        tcp_pkg::tcp_ports_t got_ports;
        tcp_pkg::tcp_ports_t exp_ports;
        tcp_pkg::ip_beat_t exp_beat;
        start = seg_start[k];
        pay_len = (sent_len[slot] > `TCP_BUF_DEPTH) ? `TCP_BUF_DEPTH : sent_len[slot];
        exp_len = 4 + pay_len;
        if (seg_len[k] < 4) begin
            report_failure("echo segment is shorter than its header");
        end
        exp_ports.src = local_port;
        exp_ports.dst = sent_src[slot];
        got_ports = {tx_beats[start].data, tx_beats[start + 1].data,
                     tx_beats[start + 2].data, tx_beats[start + 3].data};
        compare_ports(got_ports, exp_ports, "echo header ports");
        for (i = 0; i < exp_len; i++) begin
            exp_beat.valid = 1'b1;
            exp_beat.data = (i < 4) ? exp_ports[31 - 8 * i -: 8] : sent_pay[slot][i - 4];
            exp_beat.last = (i == exp_len - 1);
            compare_beat(tx_beats[start + i], exp_beat, "echo beat");
        end
    endtask

    task automatic test_registers();
        int i;
        for (i = 0; i < N; i++) begin
            cpu_write(6'(`TCP_REG_PORT_BASE + i), {16'h0000, stream_port(i)});
        end
        for (i = 0; i < N; i++) begin
            read_expect(6'(`TCP_REG_PORT_BASE + i), {16'h0000, stream_port(i)}, "port readback");
        end
        cpu_write(6'(`TCP_REG_CTRL), 32'h0000_000f);
        read_expect(6'(`TCP_REG_CTRL), 32'h0000_000f, "enable readback");
        read_expect(6'd20, 32'h0, "unmapped read");
        // counters ignore writes
        cpu_write(6'(`TCP_REG_DROP_COUNT), 32'hdead_beef);
        read_expect(6'(`TCP_REG_DROP_COUNT), 32'h0, "drop counter after write");
    endtask

    task automatic test_echo();
        int base;
        base = seg_len.size();
        send_segment(2, 16'hd431, stream_port(2), ECHO_LEN);
        rx_idle();
        exp_rx[2]++;
        wait_segments(base + 1);
        check_segment(base, 2, stream_port(2));
        repeat (IDLE_CYCLES) @(negedge i_clk);
        if (seg_len.size() != base + 1 || cur_len != 0) begin
            report_failure("echo test produced more than one segment");
        end
    endtask

    task automatic test_drops();
        int base;
        cpu_write(6'(`TCP_REG_CTRL), 32'h0000_0007);
        base = seg_len.size();
        send_segment(0, 16'h7001, 16'h1234, DROP_LEN);
        send_segment(3, 16'h7003, stream_port(3), DROP_LEN);
        rx_idle();
        exp_drops += 2;
        repeat (IDLE_CYCLES) @(negedge i_clk);
        if (seg_len.size() != base || cur_len != 0) begin
            report_failure("a dropped segment produced output on o_tx");
        end
        read_expect(6'(`TCP_REG_DROP_COUNT), 32'(exp_drops), "drop counter");
        cpu_write(6'(`TCP_REG_CTRL), 32'h0000_000f);
    endtask

    task automatic test_arbitration();
        int base;
        int i;
        int k;
        int slot;
        logic [15:0] src;
        bit seen [N];
        base = seg_len.size();
        for (i = 0; i < N; i++) begin
            seen[i] = 1'b0;
            send_segment(i, 16'(16'h9000 + i), stream_port(i), arb_len(i));
            exp_rx[i]++;
        end
        rx_idle();
        wait_segments(base + N);
        for (k = base; k < base + N; k++) begin
            src = {tx_beats[seg_start[k]].data, tx_beats[seg_start[k] + 1].data};
            slot = -1;
            for (i = 0; i < N; i++) begin
                if (stream_port(i) == src) begin
                    slot = i;
                end
            end
            if (slot < 0) begin
                report_failure("echo segment has an unknown source port");
            end else if (seen[slot]) begin
                report_failure("a stream echoed its segment twice");
            end else begin
                seen[slot] = 1'b1;
                check_segment(k, slot, stream_port(slot));
            end
        end
        repeat (IDLE_CYCLES) @(negedge i_clk);
        if (seg_len.size() != base + N || cur_len != 0) begin
            report_failure("arbitration test produced extra output on o_tx");
        end
    endtask

    task automatic test_counters();
        int i;
        for (i = 0; i < N; i++) begin
            read_expect(6'(`TCP_REG_RX_COUNT_BASE + i), 32'(exp_rx[i]), "rx counter");
        end
        read_expect(6'(`TCP_REG_DROP_COUNT), 32'(exp_drops), "final drop counter");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        i_reset = 1'b1;
        i_rx = '0;
        i_cpu_req = '0;
        exp_drops = 0;
        repeat (4) @(negedge i_clk);
        i_reset = 1'b0;

        test_registers();
        test_echo();
        test_drops();
        test_arbitration();
        test_counters();

        repeat (4) @(negedge i_clk);
        if (dut0.u_assert.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            report_failure("a bound assertion on the DUT failed");
        end
    end

endmodule

// ==== tcp_offload.f ====
+incdir+design
design/tcp_pkg.sv
design/tcp_regfile.sv
design/tcp_dest_decap.sv
design/tcp_rx_demux.sv
design/tcp_tx_arb_mux.sv
design/tcp_stream.sv
design/tcp_offload.sv
tb/tcp_offload_assert.sv
tb/tcp_offload_tb.sv

// ==== Bender.yml ====
package:
  name: tcp_offload

sources:
  - include_dirs:
      - design
    files:
      - design/tcp_pkg.sv
      - design/tcp_regfile.sv
      - design/tcp_dest_decap.sv
      - design/tcp_rx_demux.sv
      - design/tcp_tx_arb_mux.sv
      - design/tcp_stream.sv
      - design/tcp_offload.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/tcp_offload_assert.sv
      - tb/tcp_offload_tb.sv
